// File: vlog.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/instrDecode.sv
source/aluExecute.sv
source/resultStage.sv
source/intCore.sv
testbench/intCore_asserts.sv
testbench/intCore_tb.sv

// File: Makefile
TOP = intCore_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

# pass or fail comes from the log, not from the simulator's exit status
sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/intCore_tb.sv
`timescale 1ns/1ns
`include "core_params.svh"

module intCore_tb;
	import isa_pkg::*;

	// expected writeback of one table row
	typedef struct packed {
		logic     valid;
		regAddr_t dest;
		word_t    data;
	} expect_t;

	// row in flight and the cycle its writeback is due
	typedef struct packed {
		int idx;
		int due;
	} pending_t;

	logic     clk = 1'b0;
	logic     rstN_i;
	logic     instrValid_i;
	word_t    instr_i;
	logic     wbValid_o;
	regAddr_t wbReg_o;
	word_t    wbData_o;

	string    names[$];
	word_t    instrs[$];
	expect_t  expects[$];
	pending_t pending[$];
	int       cycleCount = 0;
	int       timeoutLimit = 1000;
	int       passCount = 0;
	int       failCount = 0;

	intCore i_intCore (
		.clk          (clk),
		.rstN_i       (rstN_i),
		.instrValid_i (instrValid_i),
		.instr_i      (instr_i),
		.wbValid_o    (wbValid_o),
		.wbReg_o      (wbReg_o),
		.wbData_o     (wbData_o)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// instruction encoding
	//////////////////////////////////////////////////
	function automatic word_t rType(int rs, int rt, int rd, int shamt, funct_t fn);
		return {OpRtype, regAddr_t'(rs), regAddr_t'(rt), regAddr_t'(rd), shamt_t'(shamt), fn};
	endfunction

	function automatic word_t iType(opcode_t op, int rs, int rt, int imm);
		return {op, regAddr_t'(rs), regAddr_t'(rt), imm16_t'(imm)};
	endfunction

	task automatic addRow(string name, word_t instr, logic wb, int dest, word_t data);
		expect_t e;
		e.valid = wb;
		e.dest  = regAddr_t'(dest);
		e.data  = data;
		names.push_back(name);
		instrs.push_back(instr);
		expects.push_back(e);
	endtask

	//////////////////////////////////////////////////
	// stimulus table, values worked out by hand
	//////////////////////////////////////////////////
	task automatic buildTable();
		// immediates
		addRow("addiu_neg",  iType(OpAddiu, 0, 1, 'hfffb), 1'b1, 1, 32'hffff_fffb);
		addRow("ori_zext",   iType(OpOri, 0, 2, 'h8001),   1'b1, 2, 32'h0000_8001);
		addRow("xori_zext",  iType(OpXori, 1, 3, 'h8000),  1'b1, 3, 32'hffff_7ffb);
		addRow("lui",        iType(OpLui, 0, 4, 'h1234),   1'b1, 4, 32'h1234_0000);
		addRow("slti_true",  iType(OpSlti, 1, 5, 'hfffc),  1'b1, 5, 32'h0000_0001);
		addRow("slti_false", iType(OpSlti, 2, 6, 'h7fff),  1'b1, 6, 32'h0000_0000);
		addRow("andi_zext",  iType(OpAndi, 1, 7, 'hff00),  1'b1, 7, 32'h0000_ff00);
		// chain, each row reads the one before it
		addRow("addu",       rType(4, 2, 8, 0, FnAddu),    1'b1, 8, 32'h1234_8001);
		addRow("subu",       rType(8, 1, 9, 0, FnSubu),    1'b1, 9, 32'h1234_8006);
		addRow("and",        rType(9, 3, 10, 0, FnAnd),    1'b1, 10, 32'h1234_0002);
		addRow("or",         rType(10, 2, 11, 0, FnOr),    1'b1, 11, 32'h1234_8003);
		addRow("xor",        rType(11, 4, 12, 0, FnXor),   1'b1, 12, 32'h0000_8003);
		addRow("nor",        rType(12, 0, 13, 0, FnNor),   1'b1, 13, 32'hffff_7ffc);
		addRow("slt",        rType(13, 12, 14, 0, FnSlt),  1'b1, 14, 32'h0000_0001);
		addRow("sltu",       rType(14, 13, 15, 0, FnSltu), 1'b1, 15, 32'h0000_0001);
		addRow("sll",        rType(0, 15, 16, 31, FnSll),  1'b1, 16, 32'h8000_0000);
		addRow("srl",        rType(0, 16, 17, 28, FnSrl),  1'b1, 17, 32'h0000_0008);
		// sources two and three rows back
		addRow("addiu_pos",  iType(OpAddiu, 0, 18, 'h0100), 1'b1, 18, 32'h0000_0100);
		addRow("ori_small",  iType(OpOri, 0, 19, 'h0055),   1'b1, 19, 32'h0000_0055);
		addRow("subu_dist",  rType(18, 17, 20, 0, FnSubu),  1'b1, 20, 32'h0000_00f8);
		addRow("or_dist",    rType(19, 18, 21, 0, FnOr),    1'b1, 21, 32'h0000_0155);
		// r0 is shown on the port but never holds a value
		addRow("write_r0",   iType(OpAddiu, 0, 0, 'h1234), 1'b1, 0, 32'h0000_1234);
		addRow("read_r0",    rType(0, 0, 22, 0, FnAddu),   1'b1, 22, 32'h0000_0000);
		addRow("read_r0_rf", rType(0, 21, 23, 0, FnOr),    1'b1, 23, 32'h0000_0155);
		// a load word and a multiply, neither is implemented
		addRow("bad_opcode", iType(6'h23, 0, 23, 0),       1'b0, 0, 32'h0000_0000);
		addRow("bad_funct",  rType(1, 2, 21, 0, 6'h18),    1'b0, 0, 32'h0000_0000);
		addRow("after_bubble", rType(23, 21, 24, 0, FnAddu), 1'b1, 24, 32'h0000_02aa);
	endtask

	//////////////////////////////////////////////////
	// writeback checks
	//////////////////////////////////////////////////
	task automatic checkWriteback();
		pending_t p;
		expect_t  e;
		if (pending.size() > 0 && pending[0].due == cycleCount) begin
			p = pending.pop_front();
			e = expects[p.idx];
			if (!e.valid) begin
				if (wbValid_o) begin
					$display("%s: writeback to r%0d although the instruction is unsupported",
						names[p.idx], wbReg_o);
					failCount++;
				end else begin
					$display("ok %s: no writeback", names[p.idx]);
					passCount++;
				end
			end else if (!wbValid_o) begin
				$display("%s: the expected writeback never arrived", names[p.idx]);
				failCount++;
			end else if (wbReg_o != e.dest || wbData_o != e.data) begin
				$display("FAILED %s: expected r%0d = %h, actual r%0d = %h",
					names[p.idx], e.dest, e.data, wbReg_o, wbData_o);
				failCount++;
			end else begin
				$display("ok %s: r%0d = %h", names[p.idx], wbReg_o, wbData_o);
				passCount++;
			end
		end else if (wbValid_o) begin
			$display("writeback to r%0d = %h with no instruction pending", wbReg_o, wbData_o);
			failCount++;
		end
	endtask

	// outputs are stable on the falling edge, inputs change right after
	task automatic nextCycle();
		@(negedge clk);
		cycleCount++;
		checkWriteback();
	endtask

	always @(posedge clk) begin
		if (cycleCount >= timeoutLimit) begin
			$display("timeout, the run did not finish within %0d cycles", timeoutLimit);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		int unsigned gap;
		void'($urandom(32'he2e6_66d4));
		rstN_i       = 1'b0;
		instrValid_i = 1'b0;
		instr_i      = '0;
		buildTable();
		timeoutLimit = 16 + names.size() * 4 + 10;

		repeat (16) nextCycle();
		rstN_i = 1'b1;
		repeat (2) nextCycle();
		if (failCount == 0) begin
			$display("ok reset_idle: wbValid_o stayed low");
			passCount++;
		end else begin
			$display("reset_idle: writeback seen during or right after reset");
			failCount++;
		end

		for (int i = 0; i < names.size(); i++) begin
			pending_t p;
			p.idx = i;
			p.due = cycleCount + `CORE_PIPE_DEPTH;
			instrValid_i = 1'b1;
			instr_i      = instrs[i];
			pending.push_back(p);
			nextCycle();
			// idle words carry junk that must be ignored
			instrValid_i = 1'b0;
			instr_i      = $urandom();
			gap          = $urandom_range(3, 0);
			repeat (gap) nextCycle();
		end

		while (pending.size() > 0) begin
			nextCycle();
		end
		repeat (3) nextCycle();

		$display("%0d passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: testbench/intCore_asserts.sv
`timescale 1ns/1ns
`include "core_params.svh"

module intCore_asserts (
	input logic           clk,
	input logic           rstN_i,
	input logic           instrValid_i,
	input logic           wbValid_i,
	input isa_pkg::word_t wbData_i
);

	// no writeback while held in reset
	assert property (@(posedge clk) !rstN_i |-> !wbValid_i)
		else $error("writeback valid while reset is asserted");

	// every writeback traces back to an accepted instruction
	assert property (@(posedge clk) disable iff (!rstN_i)
		wbValid_i |-> $past(instrValid_i, `CORE_PIPE_DEPTH))
		else $error("writeback without an instruction accepted at pipeline depth");

	assert property (@(posedge clk) disable iff (!rstN_i) wbValid_i |-> !$isunknown(wbData_i))
		else $error("writeback data has unknown bits");

endmodule

bind intCore intCore_asserts i_intCore_asserts (
	.clk          (clk),
	.rstN_i       (rstN_i),
	.instrValid_i (instrValid_i),
	.wbValid_i    (wbValid_o),
	.wbData_i     (wbData_o)
);

// File: source/intCore.sv
`timescale 1ns/1ns

module intCore (
	input  logic              clk,
	input  logic              rstN_i,
	input  logic              instrValid_i,
	input  isa_pkg::word_t    instr_i,
	output logic              wbValid_o,
	output isa_pkg::regAddr_t wbReg_o,
	output isa_pkg::word_t    wbData_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	decodedOp_t decoded;
	resultMsg_t exResult;
	resultMsg_t resFwd;
	regAddr_t   rdAddrA;
	regAddr_t   rdAddrB;
	word_t      rdDataA;
	word_t      rdDataB;

	//////////////////////////////////////////////////
	// decode, execute, result
	//////////////////////////////////////////////////
	instrDecode i_instrDecode (
		.clk          (clk),
		.rstN_i       (rstN_i),
		.instrValid_i (instrValid_i),
		.instr_i      (instr_i),
		.rdDataA_i    (rdDataA),
		.rdDataB_i    (rdDataB),
		.exFwd_i      (exResult),
		.resFwd_i     (resFwd),
		.rdAddrA_o    (rdAddrA),
		.rdAddrB_o    (rdAddrB),
		.decoded_o    (decoded)
	);

	aluExecute i_aluExecute (
		.clk        (clk),
		.rstN_i     (rstN_i),
		.decoded_i  (decoded),
		.exResult_o (exResult)
	);

	resultStage i_resultStage (
		.clk        (clk),
		.rstN_i     (rstN_i),
		.exResult_i (exResult),
		.rdAddrA_i  (rdAddrA),
		.rdAddrB_i  (rdAddrB),
		.rdDataA_o  (rdDataA),
		.rdDataB_o  (rdDataB),
		.resFwd_o   (resFwd),
		.wbValid_o  (wbValid_o),
		.wbReg_o    (wbReg_o),
		.wbData_o   (wbData_o)
	);

endmodule

// File: source/resultStage.sv
`timescale 1ns/1ns
`include "core_params.svh"

module resultStage (
	input  logic                 clk,
	input  logic                 rstN_i,
	input  pipe_pkg::resultMsg_t exResult_i,
	input  isa_pkg::regAddr_t    rdAddrA_i,
	input  isa_pkg::regAddr_t    rdAddrB_i,
	output isa_pkg::word_t       rdDataA_o,
	output isa_pkg::word_t       rdDataB_o,
	output pipe_pkg::resultMsg_t resFwd_o,
	output logic                 wbValid_o,
	output isa_pkg::regAddr_t    wbReg_o,
	output isa_pkg::word_t       wbData_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	resultMsg_t resQ;
	word_t      regFile [`CORE_NUM_REGS];

	// r0 is hardwired to zero
	function automatic word_t readReg(regAddr_t addr);
		return (addr == '0) ? '0 : regFile[addr];
	endfunction

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			resQ <= '0;
		end else begin
			resQ <= exResult_i;
		end
	end

	//////////////////////////////////////////////////
	// register file, written one edge after capture
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
		end else if (resQ.valid && resQ.dest != '0) begin
			regFile[resQ.dest] <= resQ.value;
		end
	end

	always_comb begin
		rdDataA_o = readReg(rdAddrA_i);
		rdDataB_o = readReg(rdAddrB_i);
	end

	// writes to r0 still show up here
	assign resFwd_o  = resQ;
	assign wbValid_o = resQ.valid;
	assign wbReg_o   = resQ.dest;
	assign wbData_o  = resQ.value;

endmodule

// File: source/aluExecute.sv
`timescale 1ns/1ns

module aluExecute (
	input  logic                 clk,
	input  logic                 rstN_i,
	input  pipe_pkg::decodedOp_t decoded_i,
	output pipe_pkg::resultMsg_t exResult_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	decodedOp_t opQ;
	word_t      aluOut;

	//////////////////////////////////////////////////
	// execute register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			opQ <= '0;
		end else begin
			opQ <= decoded_i;
		end
	end

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (opQ.aluOp)
			AluAdd:  aluOut = opQ.opA + opQ.opB;
			AluSub:  aluOut = opQ.opA - opQ.opB;
			AluAnd:  aluOut = opQ.opA & opQ.opB;
			AluOr:   aluOut = opQ.opA | opQ.opB;
			AluXor:  aluOut = opQ.opA ^ opQ.opB;
			AluNor:  aluOut = ~(opQ.opA | opQ.opB);
			// set on less than, signed and unsigned
			AluSlt:  aluOut = word_t'($signed(opQ.opA) < $signed(opQ.opB));
			AluSltu: aluOut = word_t'(opQ.opA < opQ.opB);
			// shifts act on rt, amount from the shamt field
			AluSll:  aluOut = opQ.opB << opQ.shamt;
			AluSrl:  aluOut = opQ.opB >> opQ.shamt;
			AluLui:  aluOut = {opQ.opB[15:0], 16'h0000};
			default: aluOut = '0;
		endcase
	end

	// left unregistered, decode forwards from it in the same cycle
	always_comb begin
		exResult_o.valid = opQ.valid;
		exResult_o.dest  = opQ.dest;
		exResult_o.value = aluOut;
	end

endmodule

// File: source/instrDecode.sv
`timescale 1ns/1ns

module instrDecode (
	input  logic                clk,
	input  logic                rstN_i,
	input  logic                instrValid_i,
	input  isa_pkg::word_t      instr_i,
	input  isa_pkg::word_t      rdDataA_i,
	input  isa_pkg::word_t      rdDataB_i,
	input  pipe_pkg::resultMsg_t exFwd_i,
	input  pipe_pkg::resultMsg_t resFwd_i,
	output isa_pkg::regAddr_t   rdAddrA_o,
	output isa_pkg::regAddr_t   rdAddrB_o,
	output pipe_pkg::decodedOp_t decoded_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic     instrValidQ;
	word_t    instrQ;
	opcode_t  opcode;
	funct_t   funct;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	shamt_t   shamt;
	imm16_t   imm;
	word_t    immExt;
	logic     isRtype;
	logic     supported;
	logic     signExt;
	aluOp_t   aluOp;
	word_t    srcA;
	word_t    srcB;

	// execute result is younger than the result stage
	function automatic word_t fwdOperand(regAddr_t src, word_t rfData,
			resultMsg_t ex, resultMsg_t res);
		if (src != '0 && ex.valid && ex.dest == src) begin
			return ex.value;
		end
		if (src != '0 && res.valid && res.dest == src) begin
			return res.value;
		end
		return rfData;
	endfunction

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			instrValidQ <= 1'b0;
		end else begin
			instrValidQ <= instrValid_i;
		end
	end

	always_ff @(posedge clk) begin
		instrQ <= instr_i;
	end

	assign opcode = instrQ[31:26];
	assign rs     = instrQ[25:21];
	assign rt     = instrQ[20:16];
	assign rd     = instrQ[15:11];
	assign shamt  = instrQ[10:6];
	assign funct  = instrQ[5:0];
	assign imm    = instrQ[15:0];

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////
	always_comb begin
		isRtype   = 1'b0;
		supported = 1'b1;
		signExt   = 1'b0;
		aluOp     = AluAdd;
		case (opcode)
			OpRtype: begin
				isRtype = 1'b1;
				case (funct)
					FnAddu:  aluOp = AluAdd;
					FnSubu:  aluOp = AluSub;
					FnAnd:   aluOp = AluAnd;
					FnOr:    aluOp = AluOr;
					FnXor:   aluOp = AluXor;
					FnNor:   aluOp = AluNor;
					FnSlt:   aluOp = AluSlt;
					FnSltu:  aluOp = AluSltu;
					FnSll:   aluOp = AluSll;
					FnSrl:   aluOp = AluSrl;
					default: supported = 1'b0;
				endcase
			end
			OpAddiu: begin
				signExt = 1'b1;
				aluOp   = AluAdd;
			end
			OpSlti: begin
				signExt = 1'b1;
				aluOp   = AluSlt;
			end
			OpAndi:  aluOp = AluAnd;
			OpOri:   aluOp = AluOr;
			OpXori:  aluOp = AluXor;
			OpLui:   aluOp = AluLui;
			// anything else travels on as a bubble
			default: supported = 1'b0;
		endcase
	end

	// logical immediates are zero extended
	assign immExt = signExt ? {{16{imm[15]}}, imm} : {16'h0000, imm};

	//////////////////////////////////////////////////
	// operands
	//////////////////////////////////////////////////
	assign rdAddrA_o = rs;
	assign rdAddrB_o = rt;
	assign srcA      = fwdOperand(rs, rdDataA_i, exFwd_i, resFwd_i);
	assign srcB      = fwdOperand(rt, rdDataB_i, exFwd_i, resFwd_i);

	always_comb begin
		decoded_o.valid = instrValidQ && supported;
		decoded_o.aluOp = aluOp;
		decoded_o.opA   = srcA;
		decoded_o.opB   = isRtype ? srcB : immExt;
		decoded_o.shamt = shamt;
		decoded_o.dest  = isRtype ? rd : rt;
	end

endmodule

// File: source/pipe_pkg.sv
package pipe_pkg;

	// one code per ALU function
	typedef logic [3:0] aluOp_t;

	localparam aluOp_t AluAdd  = 4'd0;
	localparam aluOp_t AluSub  = 4'd1;
	localparam aluOp_t AluAnd  = 4'd2;
	localparam aluOp_t AluOr   = 4'd3;
	localparam aluOp_t AluXor  = 4'd4;
	localparam aluOp_t AluNor  = 4'd5;
	localparam aluOp_t AluSlt  = 4'd6;
	localparam aluOp_t AluSltu = 4'd7;
	localparam aluOp_t AluSll  = 4'd8;
	localparam aluOp_t AluSrl  = 4'd9;
	localparam aluOp_t AluLui  = 4'd10;

	// decode to execute, operands already forwarded
	typedef struct packed {
		logic              valid;
		aluOp_t            aluOp;
		isa_pkg::word_t    opA;
		isa_pkg::word_t    opB;
		isa_pkg::shamt_t   shamt;
		isa_pkg::regAddr_t dest;
	} decodedOp_t;

	// execute to result, and the two forwarding paths
	typedef struct packed {
		logic              valid;
		isa_pkg::regAddr_t dest;
		isa_pkg::word_t    value;
	} resultMsg_t;

endpackage

// File: source/isa_pkg.sv
`include "core_params.svh"

package isa_pkg;

	//////////////////////////////////////////////////
	// field types
	//////////////////////////////////////////////////
	typedef logic [`CORE_XLEN-1:0]   word_t;
	typedef logic [`CORE_REG_AW-1:0] regAddr_t;
	typedef logic [5:0]              opcode_t;
	typedef logic [5:0]              funct_t;
	typedef logic [4:0]              shamt_t;
	typedef logic [15:0]             imm16_t;

	//////////////////////////////////////////////////
	// major opcodes
	//////////////////////////////////////////////////
	// special group, funct picks the operation
	localparam opcode_t OpRtype = 6'h00;
	localparam opcode_t OpAddiu = 6'h09;
	localparam opcode_t OpSlti  = 6'h0a;
	localparam opcode_t OpAndi  = 6'h0c;
	localparam opcode_t OpOri   = 6'h0d;
	localparam opcode_t OpXori  = 6'h0e;
	localparam opcode_t OpLui   = 6'h0f;

	//////////////////////////////////////////////////
	// funct values under OpRtype
	//////////////////////////////////////////////////
	localparam funct_t FnSll  = 6'h00;
	localparam funct_t FnSrl  = 6'h02;
	localparam funct_t FnAddu = 6'h21;
	localparam funct_t FnSubu = 6'h23;
	localparam funct_t FnAnd  = 6'h24;
	localparam funct_t FnOr   = 6'h25;
	localparam funct_t FnXor  = 6'h26;
	localparam funct_t FnNor  = 6'h27;
	localparam funct_t FnSlt  = 6'h2a;
	localparam funct_t FnSltu = 6'h2b;

endpackage

// File: source/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and instruction word width
`define CORE_XLEN 32

// register number width
`define CORE_REG_AW 5

// architectural registers, r0 included
`define CORE_NUM_REGS 32

// cycles from an accepting edge to the writeback port
`define CORE_PIPE_DEPTH 3

`endif
